//--- list.f
+incdir+hw
+incdir+tests
hw/tag_pkg.sv
hw/bus_pkg.sv
hw/wb_interconnect.sv
hw/tag_converter.sv
hw/event_counter.sv
hw/counter_regs.sv
hw/tagger_top.sv
tests/tb_tagger_top.sv

//--- Bender.yml
package:
  name: tagger

export_include_dirs:
  - hw

sources:
  - files:
      - hw/tag_pkg.sv
      - hw/bus_pkg.sv
      - hw/wb_interconnect.sv
      - hw/tag_converter.sv
      - hw/event_counter.sv
      - hw/counter_regs.sv
      - hw/tagger_top.sv

  - target: test
    include_dirs:
      - hw
      - tests
    files:
      - tests/tb_tagger_top.sv

//--- tests/tb_tagger_tasks.svh
// Single bus access, ack is looked for at each falling edge
task automatic bus_access(input wb_addr_t addr, input logic we,
                          input wb_data_t wdata, output wb_data_t rdata);
    int   cycles;
    logic acked;
    cycles = 0;
    acked  = 1'b0;
    rdata  = '0;
    @(posedge sys_clk);
    #2;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = addr;
    wb_dat_i = wdata;
    while (!acked && cycles < BUS_TIMEOUT) begin
        @(negedge sys_clk);
        cycles++;
        if (wb_ack_o === 1'b1) begin
            acked = 1'b1;
            rdata = wb_dat_o;
        end
    end
    if (acked) begin
        // First falling edge lies before the request is sampled
        assert (cycles - 1 == 1) else begin
            bus_errors++;
            $display("Bus ack for address 0x%h came %0d cycles after the request",
                     addr, cycles - 1);
        end
    end else begin
        timeout_errors++;
        $display("Timeout: no bus ack for address 0x%h within %0d cycles", addr, cycles);
    end
    @(posedge sys_clk);
    #2;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(negedge sys_clk);
    assert (wb_ack_o !== 1'b1) else begin
        bus_errors++;
        $display("Bus ack for address 0x%h stayed high longer than one cycle", addr);
    end
endtask

task automatic bus_write(input wb_addr_t addr, input wb_data_t data);
    wb_data_t unused;
    bus_access(addr, 1'b1, data, unused);
endtask

task automatic bus_read(input wb_addr_t addr, output wb_data_t data);
    bus_access(addr, 1'b0, '0, data);
endtask

task automatic check_read(input wb_addr_t addr, input wb_data_t exp, input string name);
    wb_data_t got;
    bus_read(addr, got);
    assert (got === exp) else begin
        bus_errors++;
        $display("ERROR wb_dat_o (%s at 0x%h): got 0x%h, expected 0x%h", name, addr, got, exp);
    end
endtask

// Every count register against the model
task automatic check_counts();
    for (int k = 0; k < `NUM_CHANNELS; k++) begin
        check_read(wb_addr_t'(`COUNTER_BASE + REG_COUNT_BASE + k), model_counts[k],
                   $sformatf("count %0d", k));
    end
endtask

// Random channel in -3..12
// Covers falling edges, fillers, counted and out of range channels
function automatic channel_t mix_channel();
    logic [31:0] r;
    r = $random(seed);
    return channel_t'(int'(r[3:0]) - 3);
endfunction

function automatic logic [`TAG_WORD_WIDTH-1:0] make_word(input channel_t ch);
    logic [31:0] r;
    r = $random(seed);
    return {ch, r[`TAG_FINE_BITS-1:0]};
endfunction

// One word per call, consecutive calls give back to back words
task automatic send_word(input logic [`TAG_WORD_WIDTH-1:0] word, input wrap_t wrap);
    channel_t ch;
    ch = channel_t'(word[`TAG_WORD_WIDTH-1:`TAG_FINE_BITS]);
    @(posedge sys_clk);
    #2;
    tag_valid_i = 1'b1;
    tag_word_i  = word;
    tag_wrap_i  = wrap;
    // Rising edges on channels 1..NUM_CHANNELS count while enabled
    if (model_en && ch >= 1 && ch <= `NUM_CHANNELS) begin
        model_counts[ch - 1] = model_counts[ch - 1] + 1;
    end
endtask

task automatic stream_idle();
    @(posedge sys_clk);
    #2;
    tag_valid_i = 1'b0;
endtask

task automatic send_mix(input int n);
    for (int i = 0; i < n; i++) begin
        send_word(make_word(mix_channel()), $random(seed));
    end
    stream_idle();
endtask

// Wait until every sent word has been compared
task automatic drain_stream();
    int cycles;
    cycles = 0;
    while (in_flight != 0 && cycles < DRAIN_TIMEOUT) begin
        @(posedge sys_clk);
        cycles++;
    end
    if (in_flight != 0) begin
        timeout_errors++;
        $display("Timeout: %0d words still in the pipeline after %0d cycles",
                 in_flight, cycles);
    end
    // Last event reaches its counter one edge later
    @(posedge sys_clk);
endtask

//--- tests/tb_tagger_top.sv
`timescale 1ns/1ps

`include "tagger_defs.svh"

module tb_tagger_top
    import tag_pkg::*;
    import bus_pkg::*;
();

    // One stream word as seen at the DUT inputs
    typedef struct packed {
        logic                       valid;
        logic [`TAG_WORD_WIDTH-1:0] word;
        wrap_t                      wrap;
    } tag_entry_t;

    localparam int BUS_TIMEOUT   = 20;
    localparam int DRAIN_TIMEOUT = 50;

    logic                       sys_clk;
    logic                       sys_clk_rst;
    logic                       tag_valid_i;
    logic [`TAG_WORD_WIDTH-1:0] tag_word_i;
    wrap_t                      tag_wrap_i;
    logic                       wb_cyc_i;
    logic                       wb_stb_i;
    logic                       wb_we_i;
    wb_addr_t                   wb_adr_i;
    wb_data_t                   wb_dat_i;
    wb_data_t                   wb_dat_o;
    logic                       wb_ack_o;
    logic                       event_valid_o;
    channel_t                   event_channel_o;
    tagtime_t                   event_tagtime_o;
    tagtime_t                   lowest_time_bound_o;

    // Words on their way through the converter pipeline
    tag_entry_t exp_q[$];
    int         in_flight;
    tagtime_t   model_bound;
    // Software count model, channel 1 at index 0
    count_t     model_counts[`NUM_CHANNELS];
    logic       model_en;
    integer     seed;
    int         stream_errors;
    int         bus_errors;
    int         timeout_errors;
    int         events_checked;

    `include "tb_tagger_tasks.svh"

    always #10 sys_clk = ~sys_clk;

    tagger_top dut_i (
        .sys_clk            (sys_clk),
        .sys_clk_rst        (sys_clk_rst),
        .tag_valid_i        (tag_valid_i),
        .tag_word_i         (tag_word_i),
        .tag_wrap_i         (tag_wrap_i),
        .wb_cyc_i           (wb_cyc_i),
        .wb_stb_i           (wb_stb_i),
        .wb_we_i            (wb_we_i),
        .wb_adr_i           (wb_adr_i),
        .wb_dat_i           (wb_dat_i),
        .wb_dat_o           (wb_dat_o),
        .wb_ack_o           (wb_ack_o),
        .event_valid_o      (event_valid_o),
        .event_channel_o    (event_channel_o),
        .event_tagtime_o    (event_tagtime_o),
        .lowest_time_bound_o(lowest_time_bound_o)
    );

    // Expected decode of one tag word
    // Timestamp is wrap count times 2^TAG_FINE_BITS plus fine time
    function automatic void ref_event(input logic [`TAG_WORD_WIDTH-1:0] word,
                                      input wrap_t wrap, output channel_t ch,
                                      output tagtime_t ts, output tagtime_t bound);
        tagtime_t wrap_time;
        wrap_time = tagtime_t'(wrap) * (tagtime_t'(1) << `TAG_FINE_BITS);
        ch        = channel_t'(word[`TAG_WORD_WIDTH-1:`TAG_FINE_BITS]);
        ts        = wrap_time + tagtime_t'(word[`TAG_FINE_BITS-1:0]);
        bound     = wrap_time;
    endfunction

    // Outputs are stable at the falling edge
    // A word seen here is taken at the next rising edge and shows one edge after that
    always @(negedge sys_clk) begin : compare_events
        tag_entry_t e;
        channel_t   exp_ch;
        tagtime_t   exp_ts;
        tagtime_t   exp_bound;
        logic       exp_valid;
        if (!sys_clk_rst) begin
            if (exp_q.size() == 2) begin
                e = exp_q.pop_front();
                ref_event(e.word, e.wrap, exp_ch, exp_ts, exp_bound);
                // Filler words raise no event
                exp_valid = e.valid && (exp_ch != 0);
                if (e.valid) begin
                    model_bound = exp_bound;
                    in_flight--;
                end
                assert (event_valid_o === exp_valid) else begin
                    stream_errors++;
                    $display("ERROR event_valid_o: got 0x%h, expected 0x%h",
                             event_valid_o, exp_valid);
                end
                if (exp_valid) begin
                    events_checked++;
                    assert (event_channel_o === exp_ch) else begin
                        stream_errors++;
                        $display("ERROR event_channel_o: got 0x%h, expected 0x%h",
                                 event_channel_o, exp_ch);
                    end
                    assert (event_tagtime_o === exp_ts) else begin
                        stream_errors++;
                        $display("ERROR event_tagtime_o: got 0x%h, expected 0x%h",
                                 event_tagtime_o, exp_ts);
                    end
                end
                assert (lowest_time_bound_o === model_bound) else begin
                    stream_errors++;
                    $display("ERROR lowest_time_bound_o: got 0x%h, expected 0x%h",
                             lowest_time_bound_o, model_bound);
                end
            end
            e.valid = tag_valid_i;
            e.word  = tag_word_i;
            e.wrap  = tag_wrap_i;
            exp_q.push_back(e);
            if (tag_valid_i) begin
                in_flight++;
            end
        end
    end

    initial begin : test_sequence
        channel_t ch;
        sys_clk        = 1'b0;
        sys_clk_rst    = 1'b1;
        tag_valid_i    = 1'b0;
        tag_word_i     = '0;
        tag_wrap_i     = '0;
        wb_cyc_i       = 1'b0;
        wb_stb_i       = 1'b0;
        wb_we_i        = 1'b0;
        wb_adr_i       = '0;
        wb_dat_i       = '0;
        in_flight      = 0;
        model_bound    = '0;
        model_en       = 1'b0;
        seed           = 32'h67462504;
        stream_errors  = 0;
        bus_errors     = 0;
        timeout_errors = 0;
        events_checked = 0;
        foreach (model_counts[k]) begin
            model_counts[k] = '0;
        end
        repeat (16) @(posedge sys_clk);
        #2;
        sys_clk_rst = 1'b0;

        // Identification region
        check_read(`TOP_BASE + TOP_ID, `ID_VALUE, "ID");
        check_read(`TOP_BASE + TOP_NCHAN, `NUM_CHANNELS, "NCHAN");

        // Back to back words with non zero channels
        for (int n = 0; n < 40; n++) begin
            ch = channel_t'($random(seed));
            if (ch == 0) begin
                ch = 1;
            end
            send_word(make_word(ch), $random(seed));
        end
        stream_idle();
        drain_stream();

        // Filler words between real ones, bound must still move
        for (int n = 0; n < 20; n++) begin
            ch = (n % 3 == 0) ? channel_t'(2) : channel_t'(0);
            send_word(make_word(ch), $random(seed));
        end
        stream_idle();
        drain_stream();

        // Events while disabled leave the counts at zero
        send_mix(30);
        drain_stream();
        check_counts();

        bus_write(`COUNTER_BASE + REG_CTRL, 32'h1);
        model_en = 1'b1;
        check_read(`COUNTER_BASE + REG_CTRL, 32'h1, "CTRL");
        send_mix(200);
        drain_stream();
        check_counts();

        // Clear, then counting restarts from zero
        bus_write(`COUNTER_BASE + REG_CLEAR, 32'h0);
        foreach (model_counts[k]) begin
            model_counts[k] = '0;
        end
        check_counts();
        check_read(`COUNTER_BASE + REG_CLEAR, 32'h0, "CLEAR");
        send_mix(100);
        drain_stream();
        check_counts();

        // Unmapped space and unused offsets
        check_read(16'h0200, 32'h0, "unmapped 0x0200");
        check_read(16'hff00, 32'h0, "unmapped 0xff00");
        check_read(`COUNTER_BASE + 16'h05, 32'h0, "counter offset 0x05");
        check_read(`COUNTER_BASE + REG_COUNT_BASE + `NUM_CHANNELS, 32'h0, "count past end");
        bus_write(16'h0200, 32'hdeadbeef);
        check_read(16'h0200, 32'h0, "unmapped 0x0200 after write");

        $display("Checked %0d events, errors: stream %0d, bus %0d, timeout %0d",
                 events_checked, stream_errors, bus_errors, timeout_errors);
        if (stream_errors + bus_errors + timeout_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- hw/tagger_top.sv
`timescale 1ns/1ps

`include "tagger_defs.svh"

module tagger_top
    import tag_pkg::*;
    import bus_pkg::*;
(
    input  logic                       sys_clk,
    input  logic                       sys_clk_rst,
    // Tag stream
    input  logic                       tag_valid_i,
    input  logic [`TAG_WORD_WIDTH-1:0] tag_word_i,
    input  wrap_t                      tag_wrap_i,
    // Register bus
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  wb_addr_t                   wb_adr_i,
    input  wb_data_t                   wb_dat_i,
    output wb_data_t                   wb_dat_o,
    output logic                       wb_ack_o,
    // Decoded events
    output logic                       event_valid_o,
    output channel_t                   event_channel_o,
    output tagtime_t                   event_tagtime_o,
    output tagtime_t                   lowest_time_bound_o
);

    // Counter region bus
    logic                       sel_cyc;
    logic                       sel_stb;
    logic                       sel_we;
    logic [`REGION_BITS-1:0]    sel_offset;
    wb_data_t                   sel_dat_w;
    wb_data_t                   sel_dat_r;
    logic                       sel_ack;

    // Counter control and counts
    logic                       count_en;
    logic                       count_clear;
    count_t [`NUM_CHANNELS-1:0] counts;

    // Tag words to timestamps
    tag_converter converter_i (
        .sys_clk            (sys_clk),
        .sys_clk_rst        (sys_clk_rst),
        .tag_valid_i        (tag_valid_i),
        .tag_word_i         (tag_word_i),
        .tag_wrap_i         (tag_wrap_i),
        .event_valid_o      (event_valid_o),
        .event_channel_o    (event_channel_o),
        .event_tagtime_o    (event_tagtime_o),
        .lowest_time_bound_o(lowest_time_bound_o)
    );

    // Rising edge counts per channel
    event_counter #(
        .NUM_CHANNELS(`NUM_CHANNELS)
    ) counter_i (
        .sys_clk        (sys_clk),
        .sys_clk_rst    (sys_clk_rst),
        .event_valid_i  (event_valid_o),
        .event_channel_i(event_channel_o),
        .count_en_i     (count_en),
        .count_clear_i  (count_clear),
        .counts_o       (counts)
    );

    // Register block beside the counter
    counter_regs regs_i (
        .sys_clk      (sys_clk),
        .sys_clk_rst  (sys_clk_rst),
        .sel_cyc_i    (sel_cyc),
        .sel_stb_i    (sel_stb),
        .sel_we_i     (sel_we),
        .sel_offset_i (sel_offset),
        .sel_dat_i    (sel_dat_w),
        .sel_dat_o    (sel_dat_r),
        .sel_ack_o    (sel_ack),
        .counts_i     (counts),
        .count_en_o   (count_en),
        .count_clear_o(count_clear)
    );

    // Address decode and ID region
    wb_interconnect interconnect_i (
        .sys_clk     (sys_clk),
        .sys_clk_rst (sys_clk_rst),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .sel_cyc_o   (sel_cyc),
        .sel_stb_o   (sel_stb),
        .sel_we_o    (sel_we),
        .sel_offset_o(sel_offset),
        .sel_dat_o   (sel_dat_w),
        .sel_dat_i   (sel_dat_r),
        .sel_ack_i   (sel_ack)
    );

endmodule

//--- hw/counter_regs.sv
`timescale 1ns/1ps

`include "tagger_defs.svh"

module counter_regs
    import tag_pkg::*;
    import bus_pkg::*;
(
    input  logic                       sys_clk,
    input  logic                       sys_clk_rst,
    // Bus slave port from the interconnect
    input  logic                       sel_cyc_i,
    input  logic                       sel_stb_i,
    input  logic                       sel_we_i,
    input  logic [`REGION_BITS-1:0]    sel_offset_i,
    input  wb_data_t                   sel_dat_i,
    output wb_data_t                   sel_dat_o,
    output logic                       sel_ack_o,
    // Counter control and readback
    input  count_t [`NUM_CHANNELS-1:0] counts_i,
    output logic                       count_en_o,
    output logic                       count_clear_o
);

    logic                    req;
    logic [`REGION_BITS-1:0] count_idx;
    wb_data_t                rd_data;

    // A request is taken once, ack blocks a repeat
    assign req = sel_cyc_i && sel_stb_i && !sel_ack_o;

    // Offset relative to the first count register
    // Offsets below the base wrap to large values
    assign count_idx = sel_offset_i - REG_COUNT_BASE;

    // Read mux
    always_comb begin
        rd_data = '0;
        if (count_idx < `NUM_CHANNELS) begin
            rd_data = counts_i[count_idx];
        end else if (sel_offset_i == REG_CTRL) begin
            rd_data = wb_data_t'(count_en_o);
        end
    end

    // Ack, enable level and clear pulse
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            sel_ack_o     <= 1'b0;
            count_en_o    <= 1'b0;
            count_clear_o <= 1'b0;
        end else begin
            sel_ack_o     <= req;
            count_clear_o <= 1'b0;
            if (req && sel_we_i) begin
                case (sel_offset_i)
                    REG_CTRL:  count_en_o <= sel_dat_i[0];
                    // One cycle pulse whatever the data
                    REG_CLEAR: count_clear_o <= 1'b1;
                    default:   ;
                endcase
            end
        end
    end

    // Read data is valid in the ack cycle
    always_ff @(posedge sys_clk) begin
        if (req) begin
            sel_dat_o <= sel_we_i ? '0 : rd_data;
        end
    end

endmodule

//--- hw/event_counter.sv
`timescale 1ns/1ps

`include "tagger_defs.svh"

module event_counter
    import tag_pkg::*;
#(
    parameter int NUM_CHANNELS = `NUM_CHANNELS
) (
    input  logic                      sys_clk,
    input  logic                      sys_clk_rst,
    // Event stream from the converter
    input  logic                      event_valid_i,
    input  channel_t                  event_channel_i,
    // Control from the register block
    input  logic                      count_en_i,
    input  logic                      count_clear_i,
    // One count per channel, channel 1 at index 0
    output count_t [NUM_CHANNELS-1:0] counts_o
);

    logic                    count_ok;
    logic [NUM_CHANNELS-1:0] hit;

    // Events count only while enabled
    assign count_ok = event_valid_i && count_en_i;

    genvar i;
    generate
        for (i = 0; i < NUM_CHANNELS; i++) begin : g_chan
            // Rising edge on channel i+1
            // Negative and out of range channels never match
            assign hit[i] = count_ok && (event_channel_i == channel_t'(i + 1));

            // Clear has priority over an increment in the same cycle
            always_ff @(posedge sys_clk) begin
                if (sys_clk_rst || count_clear_i) begin
                    counts_o[i] <= '0;
                end else if (hit[i]) begin
                    // Wraps at 2^32
                    counts_o[i] <= counts_o[i] + 1'b1;
                end
            end
        end
    endgenerate

endmodule

//--- hw/tag_converter.sv
`timescale 1ns/1ps

`include "tagger_defs.svh"

module tag_converter
    import tag_pkg::*;
(
    input  logic                       sys_clk,
    input  logic                       sys_clk_rst,
    // Incoming tag words with their wrap count
    input  logic                       tag_valid_i,
    input  logic [`TAG_WORD_WIDTH-1:0] tag_word_i,
    input  wrap_t                      tag_wrap_i,
    // Decoded events
    output logic                       event_valid_o,
    output channel_t                   event_channel_o,
    output tagtime_t                   event_tagtime_o,
    output tagtime_t                   lowest_time_bound_o
);

    // Stage 1 registers
    logic     s1_valid;
    channel_t s1_channel;
    fine_t    s1_fine;
    wrap_t    s1_wrap;
    // Wrap count in time units
    tagtime_t s1_wrap_time;

    // Stage 1 valid flag
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= tag_valid_i;
        end
    end

    // Stage 1 payload, split the word into its fields
    always_ff @(posedge sys_clk) begin
        s1_channel <= channel_t'(tag_word_i[`TAG_WORD_WIDTH-1:`TAG_FINE_BITS]);
        s1_fine    <= tag_word_i[`TAG_FINE_BITS-1:0];
        s1_wrap    <= tag_wrap_i;
    end

    assign s1_wrap_time = tagtime_t'(s1_wrap) << `TAG_FINE_BITS;

    // Stage 2 control
    // Filler words move the bound but raise no event
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            event_valid_o       <= 1'b0;
            lowest_time_bound_o <= '0;
        end else begin
            event_valid_o <= s1_valid && (s1_channel != '0);
            if (s1_valid) begin
                lowest_time_bound_o <= s1_wrap_time;
            end
        end
    end

    // Stage 2 payload, full timestamp
    always_ff @(posedge sys_clk) begin
        event_channel_o <= s1_channel;
        event_tagtime_o <= s1_wrap_time + tagtime_t'(s1_fine);
    end

endmodule

//--- hw/wb_interconnect.sv
`timescale 1ns/1ps

`include "tagger_defs.svh"

module wb_interconnect
    import bus_pkg::*;
(
    input  logic                    sys_clk,
    input  logic                    sys_clk_rst,
    // Master side
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  wb_addr_t                wb_adr_i,
    input  wb_data_t                wb_dat_i,
    output wb_data_t                wb_dat_o,
    output logic                    wb_ack_o,
    // Counter region slave
    output logic                    sel_cyc_o,
    output logic                    sel_stb_o,
    output logic                    sel_we_o,
    output logic [`REGION_BITS-1:0] sel_offset_o,
    output wb_data_t                sel_dat_o,
    input  wb_data_t                sel_dat_i,
    input  logic                    sel_ack_i
);

    slave_sel_e              slave_sel;
    wb_addr_t                adr_region;
    logic [`REGION_BITS-1:0] adr_offset;
    logic                    local_req;
    logic                    local_ack;
    wb_data_t                local_dat;

    // Split the address into region number and offset
    assign adr_region = wb_adr_i >> `REGION_BITS;
    assign adr_offset = wb_adr_i[`REGION_BITS-1:0];

    // Region decode
    always_comb begin
        if (adr_region == (`TOP_BASE >> `REGION_BITS)) begin
            slave_sel = SEL_TOP;
        end else if (adr_region == (`COUNTER_BASE >> `REGION_BITS)) begin
            slave_sel = SEL_COUNTER;
        end else begin
            slave_sel = SEL_NONE;
        end
    end

    // Counter slave sees cyc only for its own region
    assign sel_cyc_o    = wb_cyc_i && (slave_sel == SEL_COUNTER);
    assign sel_stb_o    = wb_stb_i;
    assign sel_we_o     = wb_we_i;
    assign sel_offset_o = adr_offset;
    assign sel_dat_o    = wb_dat_i;

    // ID region and unmapped space are answered here
    // New request only while our own ack is low
    assign local_req = wb_cyc_i && wb_stb_i && (slave_sel != SEL_COUNTER) && !local_ack;

    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            local_ack <= 1'b0;
        end else begin
            local_ack <= local_req;
        end
    end

    // Read data for the local responder, writes are ignored
    always_ff @(posedge sys_clk) begin
        if (local_req) begin
            local_dat <= '0;
            if (slave_sel == SEL_TOP && !wb_we_i) begin
                case (adr_offset)
                    TOP_ID:    local_dat <= `ID_VALUE;
                    TOP_NCHAN: local_dat <= wb_data_t'(`NUM_CHANNELS);
                    default:   local_dat <= '0;
                endcase
            end
        end
    end

    // Response merge
    // Only one responder can ack at a time
    assign wb_ack_o = sel_ack_i || local_ack;
    assign wb_dat_o = sel_ack_i ? sel_dat_i : local_dat;

endmodule

//--- hw/bus_pkg.sv
`include "tagger_defs.svh"

package bus_pkg;

    // Word address of the register bus
    typedef logic [15:0] wb_addr_t;

    // Bus data word
    typedef logic [31:0] wb_data_t;

    // Target of one bus access after address decode
    typedef enum logic [1:0] {
        SEL_TOP     = 2'd0,
        SEL_COUNTER = 2'd1,
        SEL_NONE    = 2'd2
    } slave_sel_e;

    // Register offsets inside the counter region
    typedef enum logic [`REGION_BITS-1:0] {
        REG_CTRL       = 8'h00,
        // Write only strobe, reads back zero
        REG_CLEAR      = 8'h01,
        // First of NUM_CHANNELS count registers
        REG_COUNT_BASE = 8'h10
    } counter_reg_e;

    // Register offsets inside the identification region
    typedef enum logic [`REGION_BITS-1:0] {
        TOP_ID    = 8'h00,
        TOP_NCHAN = 8'h01
    } top_reg_e;

endpackage

//--- hw/tag_pkg.sv
`include "tagger_defs.svh"

package tag_pkg;

    // Signed channel taken from the top bits of a tag word
    // Positive means rising edge, negative falling edge
    // Zero marks a filler word without an event
    typedef logic signed [`TAG_WORD_WIDTH-`TAG_FINE_BITS-1:0] channel_t;

    // Fine time inside one wrap period
    typedef logic [`TAG_FINE_BITS-1:0] fine_t;

    // Wrap count delivered next to each tag word
    typedef logic [31:0] wrap_t;

    // Full timestamp
    // wrap count times 2^TAG_FINE_BITS plus fine time
    typedef logic [63:0] tagtime_t;

    // Event count of one channel, wraps at 2^32
    typedef logic [31:0] count_t;

endpackage

//--- hw/tagger_defs.svh
`ifndef TAGGER_DEFS_SVH
`define TAGGER_DEFS_SVH

// Tag word layout
// Channel sits in the bits above the fine time
`define TAG_WORD_WIDTH 32
// Fine time field width
// Also the shift that turns a wrap count into time units
`define TAG_FINE_BITS 26

// Number of channels with an event counter
`define NUM_CHANNELS 8

// Identification word returned at offset ID of the top region
`define ID_VALUE 32'd1

// Region base addresses in the word address space
`define TOP_BASE 16'h0000
`define COUNTER_BASE 16'h0100

// Low address bits that form the offset inside one region
`define REGION_BITS 8

`endif
